// File: build.f
+incdir+include
src/ctrlPkg.sv
src/decodeIf.sv
src/instDecoder.sv
src/stageSequencer.sv
src/controlGenerator.sv
src/controlUnit.sv
verification/controlUnit_sva.sv
verification/ctrlChecker.sv
verification/tbControlUnit.sv

// File: include/ctrlUnit_params.svh
`ifndef CTRLUNIT_PARAMS_SVH
`define CTRLUNIT_PARAMS_SVH

`define OPCODE_WIDTH 4
`define FUNC_WIDTH   6
`define ALUOP_WIDTH  4

`define OP_BNE 4'd0
`define OP_BEQ 4'd1
`define OP_BGZ 4'd2
`define OP_BLZ 4'd3
`define OP_ADI 4'd4
`define OP_ORI 4'd5
`define OP_LHI 4'd6
`define OP_LWD 4'd7
`define OP_SWD 4'd8
`define OP_JMP 4'd9
`define OP_JAL 4'd10
`define OP_ALU 4'd15 // r-type, func selects

`define FN_ADD 6'd0
`define FN_SUB 6'd1
`define FN_AND 6'd2
`define FN_ORR 6'd3
`define FN_NOT 6'd4
`define FN_TCP 6'd5
`define FN_SHL 6'd6
`define FN_SHR 6'd7
`define FN_JPR 6'd25
`define FN_JRL 6'd26
`define FN_WWD 6'd28
`define FN_HLT 6'd29

`define ALU_ADD 4'd0
`define ALU_SUB 4'd1
`define ALU_AND 4'd2
`define ALU_ORR 4'd3
`define ALU_NOT 4'd4
`define ALU_TCP 4'd5
`define ALU_SHL 4'd6
`define ALU_SHR 4'd7
`define ALU_BNE 4'd8
`define ALU_BEQ 4'd9
`define ALU_BGZ 4'd10
`define ALU_BLZ 4'd11

`endif

// File: run.sh
#!/bin/sh
verilator --binary --assert --timescale 1ns/1ps --top-module tbControlUnit \
    -f build.f -o simControlUnit || { echo "build failed"; exit 1; }
./obj_dir/simControlUnit > sim.log 2>&1 \
    || { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || exit 0

// File: src/controlGenerator.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrlUnit_params.svh"

module controlGenerator (
    input ctrlPkg::stageT stage,
    decodeIf.generator dec,
    output logic PCWriteCond,
    output logic PCWrite,
    output logic IorD,
    output logic MemRead,
    output logic MemWrite,
    output logic MemtoReg,
    output logic IRWrite,
    output logic PCSource,
    output logic ALUSrcA,
    output logic RegWrite,
    output logic InstFlag,
    output logic HLTFlag,
    output logic WWDFlag,
    output logic ALURegWrite,
    output logic MDRWrite,
    output ctrlPkg::aluOpT ALUOp,
    output ctrlPkg::srcBSelT ALUSrcB,
    output ctrlPkg::regDstT RegDst,
    output ctrlPkg::immSelT ImmGenSig
);

    logic isMem; // load or store

    assign isMem = (dec.instClass == ctrlPkg::ClsLoad) || (dec.instClass == ctrlPkg::ClsStore);

    always_comb
    begin
        PCWriteCond = 1'b0;
        PCWrite = 1'b0;
        IorD = 1'b0;
        MemRead = 1'b0;
        MemWrite = 1'b0;
        MemtoReg = 1'b0;
        IRWrite = 1'b0;
        PCSource = 1'b0;
        ALUSrcA = 1'b0;
        RegWrite = 1'b0;
        InstFlag = 1'b0;
        HLTFlag = 1'b0;
        WWDFlag = 1'b0;
        ALURegWrite = 1'b0;
        MDRWrite = 1'b0;
        ALUOp = `ALU_ADD;
        ALUSrcB = 2'd0;
        RegDst = 2'd0;
        ImmGenSig = 2'd0;
        case (stage)
            ctrlPkg::StIf1:
            begin
                MemRead = 1'b1;
                InstFlag = 1'b1;
                ALUSrcB = 2'd1; // pc + 1
            end
            ctrlPkg::StIf2:
            begin
                MemRead = 1'b1;
                ALUSrcB = 2'd1;
            end
            ctrlPkg::StIf3:
            begin
                MemRead = 1'b1;
                IRWrite = 1'b1;
                ALURegWrite = 1'b1;
                ALUSrcB = 2'd1;
            end
            ctrlPkg::StIf4:
            begin
                PCWrite = 1'b1;
                ALUSrcB = 2'd1;
            end
            ctrlPkg::StId:
            begin
                ALUSrcB = 2'd2;
                ImmGenSig = 2'd1;
                // branch target computed early
                ALURegWrite = (dec.instClass == ctrlPkg::ClsBranch);
            end
            ctrlPkg::StEx1:
            begin
                ALUOp = dec.aluOp;
                ALUSrcA = dec.srcA;
                ALUSrcB = dec.srcB;
                ImmGenSig = dec.immSel;
                WWDFlag = (dec.instClass == ctrlPkg::ClsWwd);
            end
            ctrlPkg::StEx2:
            begin
                case (dec.instClass)
                    ctrlPkg::ClsAlu, ctrlPkg::ClsImm, ctrlPkg::ClsLoad, ctrlPkg::ClsStore:
                        ALURegWrite = 1'b1;
                    ctrlPkg::ClsJump, ctrlPkg::ClsJumpLink, ctrlPkg::ClsJumpReg,
                    ctrlPkg::ClsJumpRegLink:
                        PCWrite = 1'b1; // pc from alu result
                    ctrlPkg::ClsBranch:
                    begin
                        PCWriteCond = 1'b1;
                        PCSource = 1'b1;
                    end
                    default: PCWrite = 1'b0;
                endcase
            end
            ctrlPkg::StMem1:
            begin
                IorD = isMem;
                MemRead = (dec.instClass == ctrlPkg::ClsLoad);
            end
            ctrlPkg::StMem2:
            begin
                IorD = 1'b1;
                MDRWrite = (dec.instClass == ctrlPkg::ClsLoad);
                MemWrite = (dec.instClass == ctrlPkg::ClsStore);
            end
            ctrlPkg::StWb:
            begin
                RegWrite = 1'b1;
                case (dec.instClass)
                    ctrlPkg::ClsImm: RegDst = 2'd1;
                    ctrlPkg::ClsLoad:
                    begin
                        RegDst = 2'd1;
                        MemtoReg = 1'b1;
                    end
                    ctrlPkg::ClsJumpLink, ctrlPkg::ClsJumpRegLink: RegDst = 2'd3;
                    default: RegDst = 2'd2; // rd for r-type
                endcase
            end
            ctrlPkg::StHalt: HLTFlag = 1'b1;
            default: HLTFlag = 1'b0; // boot, all idle
        endcase
    end

endmodule

`default_nettype wire

// File: src/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input logic clk,
    input logic rst,
    input ctrlPkg::opcodeT opcode,
    input ctrlPkg::funcT func,
    output logic PCWriteCond,
    output logic PCWrite,
    output logic IorD,
    output logic MemRead,
    output logic MemWrite,
    output logic MemtoReg,
    output logic IRWrite,
    output logic PCSource,
    output logic ALUSrcA,
    output logic RegWrite,
    output logic InstFlag,
    output logic HLTFlag,
    output logic WWDFlag,
    output logic ALURegWrite,
    output logic MDRWrite,
    output ctrlPkg::aluOpT ALUOp,
    output ctrlPkg::srcBSelT ALUSrcB,
    output ctrlPkg::regDstT RegDst,
    output ctrlPkg::immSelT ImmGenSig
);

    ctrlPkg::stageT stage;

    decodeIf decBus ();

    instDecoder i_instDecoder (
        .clk(clk),
        .rst(rst),
        .opcode(opcode),
        .func(func),
        .irLoad(IRWrite), // latch at end of IF3
        .dec(decBus.decoder)
    );

    stageSequencer i_stageSequencer (
        .clk(clk),
        .rst(rst),
        .dec(decBus.sequencer),
        .stage(stage)
    );

    controlGenerator i_controlGenerator (
        .stage(stage),
        .dec(decBus.generator),
        .PCWriteCond(PCWriteCond),
        .PCWrite(PCWrite),
        .IorD(IorD),
        .MemRead(MemRead),
        .MemWrite(MemWrite),
        .MemtoReg(MemtoReg),
        .IRWrite(IRWrite),
        .PCSource(PCSource),
        .ALUSrcA(ALUSrcA),
        .RegWrite(RegWrite),
        .InstFlag(InstFlag),
        .HLTFlag(HLTFlag),
        .WWDFlag(WWDFlag),
        .ALURegWrite(ALURegWrite),
        .MDRWrite(MDRWrite),
        .ALUOp(ALUOp),
        .ALUSrcB(ALUSrcB),
        .RegDst(RegDst),
        .ImmGenSig(ImmGenSig)
    );

endmodule

`default_nettype wire

// File: src/ctrlPkg.sv
`default_nettype none

`include "ctrlUnit_params.svh"

package ctrlPkg;

    typedef logic [`OPCODE_WIDTH-1:0] opcodeT;
    typedef logic [`FUNC_WIDTH-1:0] funcT;
    typedef logic [`ALUOP_WIDTH-1:0] aluOpT;
    typedef logic [1:0] srcBSelT; // 0 reg, 1 one, 2 imm, 3 zero
    typedef logic [1:0] immSelT; // 0 none, 1 sign ext, 2 jump target
    typedef logic [1:0] regDstT; // 1 rt, 2 rd, 3 link

    typedef enum logic [3:0] {
        StBoot,
        StIf1,
        StIf2,
        StIf3,
        StIf4,
        StId,
        StEx1,
        StEx2,
        StMem1,
        StMem2,
        StWb,
        StHalt
    } stageT;

    typedef enum logic [3:0] {
        ClsAlu,
        ClsImm,
        ClsLoad,
        ClsStore,
        ClsBranch,
        ClsJump,
        ClsJumpLink,
        ClsJumpReg,
        ClsJumpRegLink,
        ClsWwd,
        ClsHalt,
        ClsNop
    } instClassT;

endpackage

`default_nettype wire

// File: src/decodeIf.sv
`timescale 1ns/1ps
`default_nettype none

interface decodeIf;

    ctrlPkg::instClassT instClass;
    ctrlPkg::aluOpT aluOp; // used in EX1 only
    logic srcA;
    ctrlPkg::srcBSelT srcB;
    ctrlPkg::immSelT immSel;

    modport decoder (output instClass, aluOp, srcA, srcB, immSel);

    // path choice needs the class alone
    modport sequencer (input instClass);

    modport generator (input instClass, aluOp, srcA, srcB, immSel);

endinterface

`default_nettype wire

// File: src/instDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrlUnit_params.svh"

module instDecoder (
    input logic clk,
    input logic rst,
    input ctrlPkg::opcodeT opcode,
    input ctrlPkg::funcT func,
    input logic irLoad,
    decodeIf.decoder dec
);

    ctrlPkg::opcodeT opReg;
    ctrlPkg::funcT funcReg;

    function automatic ctrlPkg::aluOpT fnToAluOp(input ctrlPkg::funcT fn);
        case (fn)
            `FN_ADD: return `ALU_ADD;
            `FN_SUB: return `ALU_SUB;
            `FN_AND: return `ALU_AND;
            `FN_ORR: return `ALU_ORR;
            `FN_NOT: return `ALU_NOT;
            `FN_TCP: return `ALU_TCP;
            `FN_SHL: return `ALU_SHL;
            `FN_SHR: return `ALU_SHR;
            default: return `ALU_ADD;
        endcase
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            opReg <= 4'd11; // unused opcode, decodes as nop
            funcReg <= '0;
        end
        else if (irLoad)
        begin
            opReg <= opcode;
            funcReg <= func;
        end
    end

    always_comb
    begin
        dec.instClass = ctrlPkg::ClsNop;
        dec.aluOp = `ALU_ADD;
        dec.srcA = 1'b0;
        dec.srcB = 2'd0;
        dec.immSel = 2'd0;
        case (opReg)
            `OP_BNE, `OP_BEQ, `OP_BGZ, `OP_BLZ:
            begin
                dec.instClass = ctrlPkg::ClsBranch;
                dec.srcA = 1'b1;
                case (opReg)
                    `OP_BNE: dec.aluOp = `ALU_BNE;
                    `OP_BEQ: dec.aluOp = `ALU_BEQ;
                    `OP_BGZ: dec.aluOp = `ALU_BGZ;
                    default: dec.aluOp = `ALU_BLZ;
                endcase
                // compare against zero for the sign tests
                dec.srcB = (opReg == `OP_BGZ || opReg == `OP_BLZ) ? 2'd3 : 2'd0;
            end
            `OP_ADI, `OP_ORI, `OP_LHI, `OP_LWD, `OP_SWD:
            begin
                dec.instClass = (opReg == `OP_LWD) ? ctrlPkg::ClsLoad :
                                (opReg == `OP_SWD) ? ctrlPkg::ClsStore : ctrlPkg::ClsImm;
                dec.aluOp = (opReg == `OP_ORI) ? `ALU_ORR : `ALU_ADD;
                dec.srcA = 1'b1;
                dec.srcB = 2'd2;
                dec.immSel = 2'd1; // sign extended
            end
            `OP_JMP, `OP_JAL:
            begin
                dec.instClass = (opReg == `OP_JMP) ? ctrlPkg::ClsJump : ctrlPkg::ClsJumpLink;
                dec.srcB = 2'd2;
                dec.immSel = 2'd2; // jump target
            end
            `OP_ALU:
            begin
                case (funcReg)
                    `FN_ADD, `FN_SUB, `FN_AND, `FN_ORR, `FN_NOT, `FN_TCP, `FN_SHL, `FN_SHR:
                    begin
                        dec.instClass = ctrlPkg::ClsAlu;
                        dec.aluOp = fnToAluOp(funcReg);
                        dec.srcB = (funcReg == `FN_SHL || funcReg == `FN_SHR) ? 2'd1 : 2'd0;
                    end
                    `FN_JPR, `FN_JRL:
                    begin
                        dec.instClass = (funcReg == `FN_JPR) ? ctrlPkg::ClsJumpReg :
                                        ctrlPkg::ClsJumpRegLink;
                        dec.srcA = 1'b1;
                        dec.srcB = 2'd3;
                    end
                    `FN_WWD: dec.instClass = ctrlPkg::ClsWwd;
                    `FN_HLT: dec.instClass = ctrlPkg::ClsHalt;
                    default: dec.instClass = ctrlPkg::ClsNop;
                endcase
            end
            default: dec.instClass = ctrlPkg::ClsNop; // opcodes 11 to 14
        endcase
    end

endmodule

`default_nettype wire

// File: src/stageSequencer.sv
`timescale 1ns/1ps
`default_nettype none

module stageSequencer (
    input logic clk,
    input logic rst,
    decodeIf.sequencer dec,
    output ctrlPkg::stageT stage
);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            stage <= ctrlPkg::StBoot;
        end
        else
        begin
            case (stage)
                ctrlPkg::StBoot: stage <= ctrlPkg::StIf1;
                ctrlPkg::StIf1: stage <= ctrlPkg::StIf2;
                ctrlPkg::StIf2: stage <= ctrlPkg::StIf3;
                ctrlPkg::StIf3: stage <= ctrlPkg::StIf4;
                ctrlPkg::StIf4: stage <= ctrlPkg::StId;
                ctrlPkg::StId: stage <= ctrlPkg::StEx1;
                ctrlPkg::StEx1:
                begin
                    if (dec.instClass == ctrlPkg::ClsHalt)
                        stage <= ctrlPkg::StHalt;
                    else
                        stage <= ctrlPkg::StEx2;
                end
                ctrlPkg::StEx2:
                begin
                    case (dec.instClass)
                        ctrlPkg::ClsLoad, ctrlPkg::ClsStore:
                            stage <= ctrlPkg::StMem1;
                        ctrlPkg::ClsAlu, ctrlPkg::ClsImm, ctrlPkg::ClsJumpLink,
                        ctrlPkg::ClsJumpRegLink:
                            stage <= ctrlPkg::StWb;
                        default:
                            stage <= ctrlPkg::StIf1; // branches, jumps, wwd, nop
                    endcase
                end
                ctrlPkg::StMem1: stage <= ctrlPkg::StMem2;
                ctrlPkg::StMem2:
                begin
                    if (dec.instClass == ctrlPkg::ClsLoad)
                        stage <= ctrlPkg::StWb;
                    else
                        stage <= ctrlPkg::StIf1;
                end
                ctrlPkg::StWb: stage <= ctrlPkg::StIf1;
                ctrlPkg::StHalt: stage <= ctrlPkg::StHalt; // only rst leaves
                default: stage <= ctrlPkg::StBoot;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verification/controlUnit_sva.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnitSva (
    input logic clk,
    input logic rst,
    input logic MemRead,
    input logic MemWrite,
    input logic PCWrite,
    input logic PCWriteCond,
    input logic IRWrite,
    input logic InstFlag,
    input logic HLTFlag
);

    memExclusive: assert property (@(posedge clk) disable iff (rst) !(MemRead && MemWrite))
        else $error("memory read and write strobes high together");

    pcExclusive: assert property (@(posedge clk) disable iff (rst) !(PCWrite && PCWriteCond))
        else $error("unconditional and conditional pc writes high together");

    // fetch strobe leads the instruction register load by two cycles
    irAfterFetch: assert property (@(posedge clk) disable iff (rst)
        $past(InstFlag, 2) |-> IRWrite)
        else $error("instruction register load missing two cycles after fetch");

    haltHolds: assert property (@(posedge clk) disable iff (rst) $past(HLTFlag) |-> HLTFlag)
        else $error("halt flag dropped without reset");

endmodule

bind controlUnit controlUnitSva i_controlUnitSva (
    .clk(clk),
    .rst(rst),
    .MemRead(MemRead),
    .MemWrite(MemWrite),
    .PCWrite(PCWrite),
    .PCWriteCond(PCWriteCond),
    .IRWrite(IRWrite),
    .InstFlag(InstFlag),
    .HLTFlag(HLTFlag)
);

`default_nettype wire

// File: verification/ctrlChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrlUnit_params.svh"

module ctrlChecker (
    input logic clk,
    input logic rst,
    input ctrlPkg::opcodeT opcode,
    input ctrlPkg::funcT func,
    input logic PCWriteCond, PCWrite, IorD, MemRead, MemWrite, MemtoReg, IRWrite, PCSource,
    input logic ALUSrcA, RegWrite, InstFlag, HLTFlag, WWDFlag, ALURegWrite, MDRWrite,
    input ctrlPkg::aluOpT ALUOp,
    input ctrlPkg::srcBSelT ALUSrcB,
    input ctrlPkg::regDstT RegDst,
    input ctrlPkg::immSelT ImmGenSig,
    output int errorCount,
    output int instCount
);

    ctrlPkg::stageT mStage;
    ctrlPkg::opcodeT mOp;
    ctrlPkg::funcT mFunc;
    ctrlPkg::instClassT mClass;
    logic started = 1'b0; // no prediction before the first reset edge
    logic writesBack;
    int errors = 0;
    int insts = 0;

    logic expPcWriteCond, expPcWrite, expIorD, expMemRead, expMemWrite, expMemtoReg;
    logic expIrWrite, expPcSource, expSrcA, expRegWrite, expInstFlag, expHltFlag;
    logic expWwdFlag, expAluRegWrite, expMdrWrite;
    ctrlPkg::aluOpT expAluOp;
    ctrlPkg::srcBSelT expSrcB;
    ctrlPkg::regDstT expRegDst;
    ctrlPkg::immSelT expImmSel;

    function automatic ctrlPkg::instClassT classify(input ctrlPkg::opcodeT op,
                                                    input ctrlPkg::funcT fn);
        if (op <= `OP_BLZ)
            return ctrlPkg::ClsBranch;
        if (op == `OP_ADI || op == `OP_ORI || op == `OP_LHI)
            return ctrlPkg::ClsImm;
        if (op == `OP_LWD)
            return ctrlPkg::ClsLoad;
        if (op == `OP_SWD)
            return ctrlPkg::ClsStore;
        if (op == `OP_JMP)
            return ctrlPkg::ClsJump;
        if (op == `OP_JAL)
            return ctrlPkg::ClsJumpLink;
        if (op != `OP_ALU)
            return ctrlPkg::ClsNop; // opcodes 11 to 14
        if (fn <= `FN_SHR)
            return ctrlPkg::ClsAlu;
        if (fn == `FN_JPR)
            return ctrlPkg::ClsJumpReg;
        if (fn == `FN_JRL)
            return ctrlPkg::ClsJumpRegLink;
        if (fn == `FN_WWD)
            return ctrlPkg::ClsWwd;
        if (fn == `FN_HLT)
            return ctrlPkg::ClsHalt;
        return ctrlPkg::ClsNop;
    endfunction

    task automatic compareBit(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal)
        begin
            errors++;
            $display("Fail %s expected %h actual %h at %0t", name, expVal, actVal, $time);
        end
    endtask

    task automatic compareField(input string name, input logic [3:0] expVal,
                                input logic [3:0] actVal);
        if (actVal !== expVal)
        begin
            errors++;
            $display("Fail %s expected %h actual %h at %0t", name, expVal, actVal, $time);
        end
    endtask

    assign mClass = classify(mOp, mFunc);
    assign writesBack = (mClass == ctrlPkg::ClsAlu) || (mClass == ctrlPkg::ClsImm) ||
                        (mClass == ctrlPkg::ClsJumpLink) || (mClass == ctrlPkg::ClsJumpRegLink);
    assign errorCount = errors;
    assign instCount = insts;

    always @(posedge clk)
    begin
        if (rst)
        begin
            started <= 1'b1;
            mStage <= ctrlPkg::StBoot;
        end
        else if (started)
        begin
            case (mStage)
                ctrlPkg::StBoot: mStage <= ctrlPkg::StIf1;
                ctrlPkg::StIf1: mStage <= ctrlPkg::StIf2;
                ctrlPkg::StIf2: mStage <= ctrlPkg::StIf3;
                ctrlPkg::StIf3:
                begin
                    mStage <= ctrlPkg::StIf4;
                    mOp <= opcode; // instruction taken at the end of IF3
                    mFunc <= func;
                end
                ctrlPkg::StIf4: mStage <= ctrlPkg::StId;
                ctrlPkg::StId: mStage <= ctrlPkg::StEx1;
                ctrlPkg::StEx1:
                    mStage <= (mClass == ctrlPkg::ClsHalt) ? ctrlPkg::StHalt : ctrlPkg::StEx2;
                ctrlPkg::StEx2:
                begin
                    if (mClass == ctrlPkg::ClsLoad || mClass == ctrlPkg::ClsStore)
                        mStage <= ctrlPkg::StMem1;
                    else if (writesBack)
                        mStage <= ctrlPkg::StWb;
                    else
                        mStage <= ctrlPkg::StIf1;
                end
                ctrlPkg::StMem1: mStage <= ctrlPkg::StMem2;
                ctrlPkg::StMem2:
                    mStage <= (mClass == ctrlPkg::ClsLoad) ? ctrlPkg::StWb : ctrlPkg::StIf1;
                ctrlPkg::StWb: mStage <= ctrlPkg::StIf1;
                ctrlPkg::StHalt: mStage <= ctrlPkg::StHalt;
                default: mStage <= ctrlPkg::StBoot;
            endcase
        end
    end

    always_comb
    begin
        expPcWriteCond = 1'b0;
        expPcWrite = 1'b0;
        expIorD = 1'b0;
        expMemRead = 1'b0;
        expMemWrite = 1'b0;
        expMemtoReg = 1'b0;
        expIrWrite = 1'b0;
        expPcSource = 1'b0;
        expSrcA = 1'b0;
        expRegWrite = 1'b0;
        expInstFlag = 1'b0;
        expHltFlag = 1'b0;
        expWwdFlag = 1'b0;
        expAluRegWrite = 1'b0;
        expMdrWrite = 1'b0;
        expAluOp = `ALU_ADD;
        expSrcB = 2'd0;
        expRegDst = 2'd0;
        expImmSel = 2'd0;
        case (mStage)
            ctrlPkg::StIf1:
            begin
                expMemRead = 1'b1;
                expInstFlag = 1'b1;
                expSrcB = 2'd1;
            end
            ctrlPkg::StIf2:
            begin
                expMemRead = 1'b1;
                expSrcB = 2'd1;
            end
            ctrlPkg::StIf3:
            begin
                expMemRead = 1'b1;
                expIrWrite = 1'b1;
                expAluRegWrite = 1'b1;
                expSrcB = 2'd1;
            end
            ctrlPkg::StIf4:
            begin
                expPcWrite = 1'b1;
                expSrcB = 2'd1;
            end
            ctrlPkg::StId:
            begin
                expSrcB = 2'd2;
                expImmSel = 2'd1;
                expAluRegWrite = (mClass == ctrlPkg::ClsBranch);
            end
            ctrlPkg::StEx1:
            begin
                expWwdFlag = (mClass == ctrlPkg::ClsWwd);
                case (mClass)
                    ctrlPkg::ClsAlu:
                    begin
                        expAluOp = mFunc[3:0]; // function and alu codes line up
                        expSrcB = (mFunc == `FN_SHL || mFunc == `FN_SHR) ? 2'd1 : 2'd0;
                    end
                    ctrlPkg::ClsImm, ctrlPkg::ClsLoad, ctrlPkg::ClsStore:
                    begin
                        expAluOp = (mOp == `OP_ORI) ? `ALU_ORR : `ALU_ADD;
                        expSrcA = 1'b1;
                        expSrcB = 2'd2;
                        expImmSel = 2'd1;
                    end
                    ctrlPkg::ClsBranch:
                    begin
                        expAluOp = `ALU_BNE + mOp;
                        expSrcA = 1'b1;
                        expSrcB = mOp[1] ? 2'd3 : 2'd0; // BGZ and BLZ compare with zero
                    end
                    ctrlPkg::ClsJump, ctrlPkg::ClsJumpLink:
                    begin
                        expSrcB = 2'd2;
                        expImmSel = 2'd2;
                    end
                    ctrlPkg::ClsJumpReg, ctrlPkg::ClsJumpRegLink:
                    begin
                        expSrcA = 1'b1;
                        expSrcB = 2'd3;
                    end
                    default: expAluOp = `ALU_ADD;
                endcase
            end
            ctrlPkg::StEx2:
            begin
                expAluRegWrite = (mClass == ctrlPkg::ClsAlu) || (mClass == ctrlPkg::ClsImm) ||
                                 (mClass == ctrlPkg::ClsLoad) || (mClass == ctrlPkg::ClsStore);
                expPcWrite = (mClass == ctrlPkg::ClsJump) || (mClass == ctrlPkg::ClsJumpLink) ||
                             (mClass == ctrlPkg::ClsJumpReg) ||
                             (mClass == ctrlPkg::ClsJumpRegLink);
                expPcWriteCond = (mClass == ctrlPkg::ClsBranch);
                expPcSource = (mClass == ctrlPkg::ClsBranch);
            end
            ctrlPkg::StMem1:
            begin
                expIorD = (mClass == ctrlPkg::ClsLoad) || (mClass == ctrlPkg::ClsStore);
                expMemRead = (mClass == ctrlPkg::ClsLoad);
            end
            ctrlPkg::StMem2:
            begin
                expIorD = 1'b1;
                expMdrWrite = (mClass == ctrlPkg::ClsLoad);
                expMemWrite = (mClass == ctrlPkg::ClsStore);
            end
            ctrlPkg::StWb:
            begin
                expRegWrite = 1'b1;
                expMemtoReg = (mClass == ctrlPkg::ClsLoad);
                if (mClass == ctrlPkg::ClsImm || mClass == ctrlPkg::ClsLoad)
                    expRegDst = 2'd1;
                else if (mClass == ctrlPkg::ClsJumpLink || mClass == ctrlPkg::ClsJumpRegLink)
                    expRegDst = 2'd3; // link register
                else
                    expRegDst = 2'd2;
            end
            ctrlPkg::StHalt: expHltFlag = 1'b1;
            default: expHltFlag = 1'b0;
        endcase
    end

    // outputs are settled mid cycle
    always @(negedge clk)
    begin
        if (started)
        begin
            if (mStage == ctrlPkg::StIf1)
                insts++;
            compareBit("PCWriteCond", expPcWriteCond, PCWriteCond);
            compareBit("PCWrite", expPcWrite, PCWrite);
            compareBit("IorD", expIorD, IorD);
            compareBit("MemRead", expMemRead, MemRead);
            compareBit("MemWrite", expMemWrite, MemWrite);
            compareBit("MemtoReg", expMemtoReg, MemtoReg);
            compareBit("IRWrite", expIrWrite, IRWrite);
            compareBit("PCSource", expPcSource, PCSource);
            compareBit("ALUSrcA", expSrcA, ALUSrcA);
            compareBit("RegWrite", expRegWrite, RegWrite);
            compareBit("InstFlag", expInstFlag, InstFlag);
            compareBit("HLTFlag", expHltFlag, HLTFlag);
            compareBit("WWDFlag", expWwdFlag, WWDFlag);
            compareBit("ALURegWrite", expAluRegWrite, ALURegWrite);
            compareBit("MDRWrite", expMdrWrite, MDRWrite);
            compareField("ALUOp", expAluOp, ALUOp);
            compareField("ALUSrcB", {2'b00, expSrcB}, {2'b00, ALUSrcB});
            compareField("RegDst", {2'b00, expRegDst}, {2'b00, RegDst});
            compareField("ImmGenSig", {2'b00, expImmSel}, {2'b00, ImmGenSig});
        end
    end

endmodule

`default_nettype wire

// File: verification/tbControlUnit.sv
`timescale 1ns/1ps
`default_nettype none

`include "ctrlUnit_params.svh"

module tbControlUnit;

    logic clk;
    logic rst;
    ctrlPkg::opcodeT opcode = '0;
    ctrlPkg::funcT func = '0;
    logic PCWriteCond, PCWrite, IorD, MemRead, MemWrite, MemtoReg, IRWrite, PCSource;
    logic ALUSrcA, RegWrite, InstFlag, HLTFlag, WWDFlag, ALURegWrite, MDRWrite;
    ctrlPkg::aluOpT ALUOp;
    ctrlPkg::srcBSelT ALUSrcB;
    ctrlPkg::regDstT RegDst;
    ctrlPkg::immSelT ImmGenSig;
    int errorCount;
    int instCount;

    logic [16:0] lfsrState = 17'd75234;

    // twelve defined functions, then four unused codes
    ctrlPkg::funcT funcTable [16] = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_ORR, `FN_NOT, `FN_TCP,
                                      `FN_SHL, `FN_SHR, `FN_JPR, `FN_JRL, `FN_WWD, `FN_HLT,
                                      6'd8, 6'd20, 6'd27, 6'd63};

    controlUnit i_controlUnit (.*);

    ctrlChecker i_ctrlChecker (.*);

    // x^17 + x^14 + 1
    function automatic logic [16:0] lfsrNext(input logic [16:0] state);
        return {state[15:0], state[16] ^ state[13]};
    endfunction

    task automatic drawNibble(output logic [3:0] value);
        value = '0;
        for (int i = 0; i < 4; i++)
        begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[2:0], lfsrState[0]};
        end
    endtask

    task automatic applyReset(output logic fetched);
        int waitCount;
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        waitCount = 0;
        // boot cycle, then the first fetch
        do
        begin
            @(negedge clk);
            waitCount++;
        end
        while (!InstFlag && waitCount < 4);
        fetched = InstFlag;
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin : driveInputs
        logic [3:0] bits;
        #1;
        drawNibble(bits);
        opcode = bits;
        drawNibble(bits);
        func = funcTable[bits];
    end

    initial
    begin : runTest
        int pulses;
        int cycles;
        int haltCycles;
        logic fetched;
        logic timedOut;
        rst = 1'b1;
        timedOut = 1'b0;
        pulses = 0;
        cycles = 0;
        applyReset(fetched);
        if (!fetched)
            timedOut = 1'b1;
        else
            pulses++;
        while (!timedOut && pulses < 400 && cycles < 8000)
        begin
            @(negedge clk);
            cycles++;
            if (InstFlag)
                pulses++;
            if (HLTFlag)
            begin
                haltCycles = 0;
                while (HLTFlag && haltCycles < 3) // let the halt persist a little
                begin
                    @(negedge clk);
                    haltCycles++;
                end
                @(posedge clk);
                #1;
                applyReset(fetched);
                if (!fetched)
                    timedOut = 1'b1;
                else
                    pulses++;
            end
        end
        if (timedOut)
            $display("no instruction fetch followed a reset within 4 cycles");
        else if (pulses < 400)
        begin
            $display("cycle limit reached before 400 instructions were fetched");
            timedOut = 1'b1;
        end
        @(posedge clk);
        $display("errors %0d, instructions %0d, timeouts %0d", errorCount, instCount, timedOut);
        if (errorCount == 0 && !timedOut)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
